// File: Makefile
TB_TOP  = lsu_tb
RTL_TOP = lsu_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TB_TOP) -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
+incdir+src
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_req_if.sv
src/lsu_agen.sv
src/lsu_stage_m.sv
src/lsu_biu_ctrl.sv
src/lsu_load_align.sv
src/lsu_top.sv
tests/lsu_tb.sv

// File: src/lsu_agen.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_agen
   import lsu_op_pkg::*, lsu_bus_pkg::*;
   (
   input  logic     valid_e,
   input  lsu_op_t  lsu_op,
   input  addr_t    base,
   input  addr_t    offset,
   input  word_t    wdata,
   lsu_e_if.agen    e
   );

   logic      access;
   logic      is_store;
   logic      is_unsigned;
   acc_size_t size;
   addr_t     addr;
   logic      ale;
   strb_t     strb;
   word_t     st_data;

   // ========================================
   // op decode
   // ========================================
   always_comb begin
      access      = 1'b1;
      is_store    = 1'b0;
      is_unsigned = 1'b0;
      size        = `LSU_SIZE_W;
      case (lsu_op)
         `LSU_OP_LD_B:  size = `LSU_SIZE_B;
         `LSU_OP_LD_H:  size = `LSU_SIZE_H;
         `LSU_OP_LD_W:  size = `LSU_SIZE_W;
         `LSU_OP_LD_BU: begin
            size        = `LSU_SIZE_B;
            is_unsigned = 1'b1;
         end
         `LSU_OP_LD_HU: begin
            size        = `LSU_SIZE_H;
            is_unsigned = 1'b1;
         end
         `LSU_OP_ST_B: begin
            size     = `LSU_SIZE_B;
            is_store = 1'b1;
         end
         `LSU_OP_ST_H: begin
            size     = `LSU_SIZE_H;
            is_store = 1'b1;
         end
         `LSU_OP_ST_W:  is_store = 1'b1;
         default:       access = 1'b0;
      endcase
   end

   assign addr = base + offset;

   // half needs bit 0 clear, word needs bits 1:0 clear
   assign ale = access &
                (((size == `LSU_SIZE_H) & addr[0]) |
                 ((size == `LSU_SIZE_W) & (addr[1:0] != 2'b00)));

   // ========================================
   // store lanes
   // ========================================
   always_comb begin
      case (size)
         `LSU_SIZE_B: begin
            strb    = 4'b0001 << addr[1:0];
            st_data = {4{wdata[7:0]}};
         end
         `LSU_SIZE_H: begin
            strb    = 4'b0011 << addr[1:0];
            st_data = {2{wdata[15:0]}};
         end
         default: begin
            strb    = 4'b1111;
            st_data = wdata;
         end
      endcase
   end

   assign e.go          = valid_e & access & ~ale;
   assign e.ale         = ale;
   assign e.is_store    = is_store;
   assign e.size        = size;
   assign e.is_unsigned = is_unsigned;
   assign e.addr        = addr;
   assign e.wdata       = st_data;
   assign e.strb        = strb;

endmodule

// File: src/lsu_biu_ctrl.sv
`timescale 1ns/1ps

module lsu_biu_ctrl
   import lsu_bus_pkg::*;
   (
   input  logic   clk,
   input  logic   reset,
   lsu_m_if.biu   m,

   output logic   lsu_biu_rd_req,
   output addr_t  lsu_biu_rd_addr,
   input  logic   biu_lsu_rd_ack,
   input  logic   biu_lsu_data_valid,

   output logic   lsu_biu_wr_req,
   output addr_t  lsu_biu_wr_addr,
   output word_t  lsu_biu_wr_data,
   output strb_t  lsu_biu_wr_strb,
   input  logic   biu_lsu_wr_ack,
   input  logic   biu_lsu_write_done,

   output logic   lsu_addr_finish,
   output logic   lsu_finish_m,
   input  logic   ale_e
   );

   bus_state_t state_q;
   bus_state_t state_d;
   logic       req_active;
   logic       ack;
   logic       done;

   // only the handshake of the current direction counts
   assign ack  = m.is_store ? biu_lsu_wr_ack : biu_lsu_rd_ack;
   assign done = m.is_store ? biu_lsu_write_done : biu_lsu_data_valid;

   // ========================================
   // request FSM
   // ========================================
   always_comb begin
      state_d = state_q;
      case (state_q)
         BUS_IDLE: begin
            // ack may already come in the issue cycle
            if (m.issue) begin
               state_d = ack ? BUS_WAIT : BUS_REQ;
            end
         end
         BUS_REQ: begin
            if (ack) begin
               state_d = BUS_WAIT;
            end
         end
         BUS_WAIT: begin
            if (done) begin
               state_d = BUS_IDLE;
            end
         end
         default: state_d = BUS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= BUS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // request goes out straight from issue, then holds in BUS_REQ
   assign req_active = (state_q == BUS_REQ) | ((state_q == BUS_IDLE) & m.issue);

   assign lsu_biu_rd_req  = req_active & ~m.is_store;
   assign lsu_biu_wr_req  = req_active & m.is_store;
   assign lsu_biu_rd_addr = m.addr;
   assign lsu_biu_wr_addr = m.addr;
   assign lsu_biu_wr_data = m.wdata;
   assign lsu_biu_wr_strb = m.strb;

   // misaligned ops finish without touching the bus
   assign lsu_addr_finish = biu_lsu_rd_ack | biu_lsu_wr_ack | ale_e;
   assign lsu_finish_m    = biu_lsu_data_valid | biu_lsu_write_done | m.ale_done;

endmodule

// File: src/lsu_bus_pkg.sv
`include "lsu_consts.svh"

package lsu_bus_pkg;

   // ========================================
   // bus side types
   // ========================================

   // byte address
   typedef logic [`LSU_GRLEN-1:0] addr_t;

   // register width data, also the store data
   typedef logic [`LSU_GRLEN-1:0] word_t;

   // one read beat from the biu
   typedef logic [`LSU_BIU_DW-1:0] beat_t;

   // byte strobes for one word
   typedef logic [`LSU_GRLEN/8-1:0] strb_t;

   // single outstanding request tracker
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_REQ,
      BUS_WAIT
   } bus_state_t;

endpackage

// File: src/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// widths
`define LSU_GRLEN      32
`define LSU_BIU_DW     64
`define LSU_REG_IDX_W  5
`define LSU_OP_W       4

// operation codes, anything else is a no-access op
`define LSU_OP_LD_B    4'd0
`define LSU_OP_LD_H    4'd1
`define LSU_OP_LD_W    4'd2
`define LSU_OP_LD_BU   4'd4
`define LSU_OP_LD_HU   4'd5
`define LSU_OP_ST_B    4'd8
`define LSU_OP_ST_H    4'd9
`define LSU_OP_ST_W    4'd10

// access size codes
`define LSU_SIZE_B     2'd0
`define LSU_SIZE_H     2'd1
`define LSU_SIZE_W     2'd2

`endif

// File: src/lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_load_align
   import lsu_bus_pkg::*;
   (
   lsu_m_if.align m,
   input  beat_t  biu_lsu_data,
   output word_t  read_result_m
   );

   word_t       half_sel;
   logic [7:0]  byte_val;
   logic [15:0] half_val;

   // bit 2 picks the 32-bit half of the 64-bit beat
   assign half_sel = m.addr[2] ? biu_lsu_data[63:32] : biu_lsu_data[31:0];

   assign byte_val = half_sel[{m.addr[1:0], 3'b000} +: 8];
   assign half_val = m.addr[1] ? half_sel[31:16] : half_sel[15:0];

   // extension by size
   always_comb begin
      case (m.size)
         `LSU_SIZE_B: begin
            if (m.is_unsigned) begin
               read_result_m = {24'd0, byte_val};
            end else begin
               read_result_m = {{24{byte_val[7]}}, byte_val};
            end
         end
         `LSU_SIZE_H: begin
            if (m.is_unsigned) begin
               read_result_m = {16'd0, half_val};
            end else begin
               read_result_m = {{16{half_val[15]}}, half_val};
            end
         end
         default: read_result_m = half_sel;
      endcase
   end

endmodule

// File: src/lsu_op_pkg.sv
`include "lsu_consts.svh"

package lsu_op_pkg;

   // ========================================
   // operation side types
   // ========================================

   // raw operation code from the decoder
   typedef logic [`LSU_OP_W-1:0] lsu_op_t;

   // destination register index
   typedef logic [`LSU_REG_IDX_W-1:0] reg_idx_t;

   // access size, one of the LSU_SIZE codes
   typedef logic [1:0] acc_size_t;

endpackage

// File: src/lsu_req_if.sv
`timescale 1ns/1ps

// decoded access at E, sampled while valid_e is high
interface lsu_e_if
   import lsu_op_pkg::*, lsu_bus_pkg::*;
   ();

   logic      go;
   logic      ale;
   logic      is_store;
   acc_size_t size;
   logic      is_unsigned;
   addr_t     addr;
   word_t     wdata;
   strb_t     strb;

   modport agen (
      output go, ale, is_store, size, is_unsigned, addr, wdata, strb
   );

   modport stage (
      input go, ale, is_store, size, is_unsigned, addr, wdata, strb
   );

endinterface

// registered access at M, feeds the bus control and load align
interface lsu_m_if
   import lsu_op_pkg::*, lsu_bus_pkg::*;
   ();

   logic      issue;
   logic      ale_done;
   logic      is_store;
   acc_size_t size;
   logic      is_unsigned;
   addr_t     addr;
   word_t     wdata;
   strb_t     strb;

   modport stage (
      output issue, ale_done, is_store, size, is_unsigned, addr, wdata, strb
   );

   modport biu (
      input issue, ale_done, is_store, addr, wdata, strb
   );

   modport align (
      input size, is_unsigned, addr
   );

endinterface

// File: src/lsu_stage_m.sv
`timescale 1ns/1ps

module lsu_stage_m
   import lsu_op_pkg::*;
   (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid_e,
   input  reg_idx_t ecl_lsu_rd_e,
   input  logic     ecl_lsu_wen_e,
   lsu_e_if.stage   e,
   lsu_m_if.stage   m,
   output reg_idx_t lsu_ecl_rd_m,
   output logic     lsu_ecl_wen_m
   );

   // ========================================
   // one-cycle pulses into M
   // ========================================
   always_ff @(posedge clk) begin
      if (reset) begin
         m.issue    <= 1'b0;
         m.ale_done <= 1'b0;
      end else begin
         m.issue    <= e.go;
         m.ale_done <= valid_e & e.ale;
      end
   end

   // write enable goes back to the core, so clear it on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_ecl_wen_m <= 1'b0;
      end else if (valid_e) begin
         lsu_ecl_wen_m <= ecl_lsu_wen_e;
      end
   end

   // ========================================
   // E to M payload
   // ========================================
   // held until the next valid_e, one op in flight at a time
   always_ff @(posedge clk) begin
      if (valid_e) begin
         m.is_store    <= e.is_store;
         m.size        <= e.size;
         m.is_unsigned <= e.is_unsigned;
         m.addr        <= e.addr;
         m.wdata       <= e.wdata;
         m.strb        <= e.strb;
         lsu_ecl_rd_m  <= ecl_lsu_rd_e;
      end
   end

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
   import lsu_op_pkg::*, lsu_bus_pkg::*;
   (
   input  logic     clk,
   input  logic     reset,

   // core side, E stage
   input  logic     valid_e,
   input  lsu_op_t  lsu_op,
   input  addr_t    base,
   input  addr_t    offset,
   input  word_t    wdata,
   input  reg_idx_t ecl_lsu_rd_e,
   input  logic     ecl_lsu_wen_e,

   // biu read side
   output logic     lsu_biu_rd_req,
   output addr_t    lsu_biu_rd_addr,
   input  logic     biu_lsu_rd_ack,
   input  logic     biu_lsu_data_valid,
   input  beat_t    biu_lsu_data,

   // biu write side
   output logic     lsu_biu_wr_req,
   output addr_t    lsu_biu_wr_addr,
   output word_t    lsu_biu_wr_data,
   output strb_t    lsu_biu_wr_strb,
   input  logic     biu_lsu_wr_ack,
   input  logic     biu_lsu_write_done,

   // results back to the core
   output logic     lsu_addr_finish,
   output word_t    read_result_m,
   output logic     lsu_finish_m,
   output reg_idx_t lsu_ecl_rd_m,
   output logic     lsu_ecl_wen_m,
   output logic     lsu_ecl_ale_e,
   output addr_t    lsu_csr_badv_e
   );

   lsu_e_if e_if ();
   lsu_m_if m_if ();

   // exception outputs at E
   assign lsu_ecl_ale_e  = valid_e & e_if.ale;
   assign lsu_csr_badv_e = e_if.addr;

   lsu_agen u_agen (
      .valid_e (valid_e),
      .lsu_op  (lsu_op),
      .base    (base),
      .offset  (offset),
      .wdata   (wdata),
      .e       (e_if.agen)
   );

   lsu_stage_m u_stage_m (
      .clk           (clk),
      .reset         (reset),
      .valid_e       (valid_e),
      .ecl_lsu_rd_e  (ecl_lsu_rd_e),
      .ecl_lsu_wen_e (ecl_lsu_wen_e),
      .e             (e_if.stage),
      .m             (m_if.stage),
      .lsu_ecl_rd_m  (lsu_ecl_rd_m),
      .lsu_ecl_wen_m (lsu_ecl_wen_m)
   );

   lsu_biu_ctrl u_biu_ctrl (
      .clk                (clk),
      .reset              (reset),
      .m                  (m_if.biu),
      .lsu_biu_rd_req     (lsu_biu_rd_req),
      .lsu_biu_rd_addr    (lsu_biu_rd_addr),
      .biu_lsu_rd_ack     (biu_lsu_rd_ack),
      .biu_lsu_data_valid (biu_lsu_data_valid),
      .lsu_biu_wr_req     (lsu_biu_wr_req),
      .lsu_biu_wr_addr    (lsu_biu_wr_addr),
      .lsu_biu_wr_data    (lsu_biu_wr_data),
      .lsu_biu_wr_strb    (lsu_biu_wr_strb),
      .biu_lsu_wr_ack     (biu_lsu_wr_ack),
      .biu_lsu_write_done (biu_lsu_write_done),
      .lsu_addr_finish    (lsu_addr_finish),
      .lsu_finish_m       (lsu_finish_m),
      .ale_e              (lsu_ecl_ale_e)
   );

   lsu_load_align u_load_align (
      .m             (m_if.align),
      .biu_lsu_data  (biu_lsu_data),
      .read_result_m (read_result_m)
   );

endmodule

// File: tests/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb
   import lsu_op_pkg::*, lsu_bus_pkg::*;
   ();

   localparam int NUM_ROWS = 64;
   localparam int TIMEOUT  = 50;

   logic     clk;
   logic     reset;
   logic     valid_e;
   lsu_op_t  lsu_op;
   addr_t    base;
   addr_t    offset;
   word_t    wdata;
   reg_idx_t ecl_lsu_rd_e;
   logic     ecl_lsu_wen_e;
   logic     lsu_biu_rd_req;
   addr_t    lsu_biu_rd_addr;
   logic     biu_lsu_rd_ack;
   logic     biu_lsu_data_valid;
   beat_t    biu_lsu_data;
   logic     lsu_biu_wr_req;
   addr_t    lsu_biu_wr_addr;
   word_t    lsu_biu_wr_data;
   strb_t    lsu_biu_wr_strb;
   logic     biu_lsu_wr_ack;
   logic     biu_lsu_write_done;
   logic     lsu_addr_finish;
   word_t    read_result_m;
   logic     lsu_finish_m;
   reg_idx_t lsu_ecl_rd_m;
   logic     lsu_ecl_wen_m;
   logic     lsu_ecl_ale_e;
   addr_t    lsu_csr_badv_e;

   // stimulus table with the expected ale per row
   lsu_op_t  tbl_op     [NUM_ROWS];
   addr_t    tbl_base   [NUM_ROWS];
   addr_t    tbl_offset [NUM_ROWS];
   word_t    tbl_wdata  [NUM_ROWS];
   beat_t    tbl_beat   [NUM_ROWS];
   reg_idx_t tbl_rd     [NUM_ROWS];
   logic     tbl_wen    [NUM_ROWS];
   logic     tbl_ale    [NUM_ROWS];

   integer seed = 5;
   int     errors = 0;
   logic   abort;

   lsu_top u_lsu_top (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   // ========================================
   // reference model
   // ========================================
   function automatic int size_of(input lsu_op_t op);
      case (op)
         `LSU_OP_LD_B, `LSU_OP_LD_BU, `LSU_OP_ST_B: size_of = 1;
         `LSU_OP_LD_H, `LSU_OP_LD_HU, `LSU_OP_ST_H: size_of = 2;
         default: size_of = 4;
      endcase
   endfunction

   function automatic logic is_store_op(input lsu_op_t op);
      return op == `LSU_OP_ST_B || op == `LSU_OP_ST_H || op == `LSU_OP_ST_W;
   endfunction

   // lanes covered by the access inside its word
   function automatic strb_t exp_strb(input lsu_op_t op, input addr_t addr);
      int    lo;
      strb_t s;
      lo = (size_of(op) == 4) ? 0 : int'(addr[1:0]);
      for (int b = 0; b < 4; b++) begin
         s[b] = (b >= lo) && (b < lo + size_of(op));
      end
      return s;
   endfunction

   // every lane repeats the low bytes of the store value
   function automatic word_t exp_wdata(input lsu_op_t op, input word_t d);
      word_t w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = d[8*(b % size_of(op)) +: 8];
      end
      return w;
   endfunction

   function automatic word_t exp_load(input lsu_op_t op, input addr_t addr, input beat_t beat);
      beat_t raw;
      int    n;
      logic  sgn;
      raw = beat >> (8 * int'(addr[2:0]));
      n   = 8 * size_of(op);
      sgn = (op == `LSU_OP_LD_B || op == `LSU_OP_LD_H) && raw[n-1];
      for (int k = 0; k < 32; k++) begin
         if (k >= n) begin
            raw[k] = sgn;
         end
      end
      return raw[31:0];
   endfunction

   function automatic logic req_of(input logic st);
      return st ? lsu_biu_wr_req : lsu_biu_rd_req;
   endfunction

   function automatic addr_t req_addr(input logic st);
      return st ? lsu_biu_wr_addr : lsu_biu_rd_addr;
   endfunction

   task automatic set_bus(input logic st, input logic ack, input logic done);
      biu_lsu_rd_ack     = ~st & ack;
      biu_lsu_wr_ack     = st & ack;
      biu_lsu_data_valid = ~st & done;
      biu_lsu_write_done = st & done;
   endtask

   // eight ops times every byte offset in a beat
   task automatic fill_table();
      lsu_op_t     ops [8];
      logic [31:0] r;
      ops = '{`LSU_OP_LD_B, `LSU_OP_LD_H, `LSU_OP_LD_W, `LSU_OP_LD_BU,
              `LSU_OP_LD_HU, `LSU_OP_ST_B, `LSU_OP_ST_H, `LSU_OP_ST_W};
      for (int i = 0; i < NUM_ROWS; i++) begin
         r             = $random(seed);
         tbl_op[i]     = ops[i / 8];
         tbl_base[i]   = $random(seed) & 32'hffff_fff8;
         tbl_offset[i] = i % 8;
         tbl_wdata[i]  = $random(seed);
         tbl_beat[i]   = {$random(seed), $random(seed)};
         tbl_rd[i]     = r[4:0];
         tbl_wen[i]    = r[8];
         tbl_ale[i]    = ((tbl_base[i] + tbl_offset[i]) % size_of(tbl_op[i])) != 0;
      end
   endtask

   // ========================================
   // one access with the biu model
   // ========================================
   task automatic run_row(input int i);
      addr_t addr;
      addr_t held;
      logic  st;
      int    cyc;
      int    ack_at;
      int    done_at;
      addr    = tbl_base[i] + tbl_offset[i];
      st      = is_store_op(tbl_op[i]);
      ack_at  = {$random(seed)} % 4;
      done_at = 1 + {$random(seed)} % 3;

      @(negedge clk);
      valid_e       = 1'b1;
      lsu_op        = tbl_op[i];
      base          = tbl_base[i];
      offset        = tbl_offset[i];
      wdata         = tbl_wdata[i];
      ecl_lsu_rd_e  = tbl_rd[i];
      ecl_lsu_wen_e = tbl_wen[i];
      #1;
      check("lsu_ecl_ale_e", lsu_ecl_ale_e, tbl_ale[i]);
      check("lsu_csr_badv_e", lsu_csr_badv_e, addr);
      check("lsu_addr_finish", lsu_addr_finish, tbl_ale[i]);
      check("lsu_finish_m", lsu_finish_m, 0);

      // scramble E inputs while M holds
      @(negedge clk);
      valid_e       = 1'b0;
      lsu_op        = 4'hf;
      base          = $random(seed);
      offset        = ~tbl_offset[i];
      wdata         = ~tbl_wdata[i];
      ecl_lsu_rd_e  = ~tbl_rd[i];
      ecl_lsu_wen_e = ~tbl_wen[i];
      if (tbl_ale[i]) begin
         #1;
         check("lsu_finish_m", lsu_finish_m, 1);
         check("lsu_biu_rd_req", lsu_biu_rd_req, 0);
         check("lsu_biu_wr_req", lsu_biu_wr_req, 0);
         check("lsu_ecl_rd_m", lsu_ecl_rd_m, tbl_rd[i]);
         check("lsu_ecl_wen_m", lsu_ecl_wen_m, tbl_wen[i]);
         return;
      end
      cyc = 0;
      while (!req_of(st) && cyc < TIMEOUT) begin
         @(negedge clk);
         cyc++;
      end
      if (cyc == TIMEOUT) begin
         $display("timeout: no bus request seen for table row %0d", i);
         errors++;
         abort = 1'b1;
         return;
      end
      check("request latency", cyc, 0);
      check("other request", req_of(~st), 0);
      held = req_addr(st);
      check("request address", held, addr);
      if (st) begin
         check("lsu_biu_wr_data", lsu_biu_wr_data, exp_wdata(tbl_op[i], tbl_wdata[i]));
         check("lsu_biu_wr_strb", lsu_biu_wr_strb, exp_strb(tbl_op[i], addr));
      end
      // back-pressure
      repeat (ack_at) begin
         #1;
         check("request held", req_of(st), 1);
         check("request address held", req_addr(st), held);
         check("lsu_addr_finish", lsu_addr_finish, 0);
         @(negedge clk);
      end
      set_bus(st, 1'b1, 1'b0);
      #1;
      check("request at ack", req_of(st), 1);
      check("lsu_addr_finish", lsu_addr_finish, 1);
      check("lsu_ecl_rd_m", lsu_ecl_rd_m, tbl_rd[i]);
      check("lsu_ecl_wen_m", lsu_ecl_wen_m, tbl_wen[i]);
      @(negedge clk);
      set_bus(st, 1'b0, 1'b0);
      repeat (done_at - 1) begin
         #1;
         check("request after ack", req_of(st), 0);
         check("lsu_finish_m", lsu_finish_m, 0);
         @(negedge clk);
      end
      set_bus(st, 1'b0, 1'b1);
      biu_lsu_data = tbl_beat[i];
      #1;
      check("request after ack", req_of(st), 0);
      check("lsu_finish_m", lsu_finish_m, 1);
      if (!st) begin
         check("read_result_m", read_result_m, exp_load(tbl_op[i], addr, tbl_beat[i]));
      end
      @(negedge clk);
      set_bus(st, 1'b0, 1'b0);
      biu_lsu_data = ~tbl_beat[i];
   endtask

   // ========================================
   // main sequence
   // ========================================
   initial begin
      valid_e            = 1'b0;
      lsu_op             = 4'hf;
      base               = '0;
      offset             = '0;
      wdata              = '0;
      ecl_lsu_rd_e       = '0;
      ecl_lsu_wen_e      = 1'b0;
      biu_lsu_rd_ack     = 1'b0;
      biu_lsu_data_valid = 1'b0;
      biu_lsu_data       = '0;
      biu_lsu_wr_ack     = 1'b0;
      biu_lsu_write_done = 1'b0;
      abort              = 1'b0;
      reset              = 1'b1;
      fill_table();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #1;
      check("lsu_biu_rd_req", lsu_biu_rd_req, 0);
      check("lsu_biu_wr_req", lsu_biu_wr_req, 0);
      check("lsu_finish_m", lsu_finish_m, 0);
      check("lsu_addr_finish", lsu_addr_finish, 0);
      check("lsu_ecl_wen_m", lsu_ecl_wen_m, 0);
      for (int i = 0; i < NUM_ROWS && !abort; i++) begin
         run_row(i);
      end
      $display("run finished with %0d error(s)", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
